// File: compile.f
source/host_bridge_pkg.sv
source/host_reg_if.sv
source/word_fifo.sv
source/host_in_path.sv
source/host_out_path.sv
source/axi_reg_fsm.sv
source/host_bridge_top.sv
sim/tb_clock_gen.sv
sim/tb_host_bridge.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the host bridge testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f compile.f \
  --top-module tb_host_bridge -o tb_host_bridge \
  && ./obj_dir/tb_host_bridge | tee sim.log \
  || { echo "Build or simulation run failed"; exit 1; }

grep -q "^NO ERRORS$" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

// File: sim/tb_host_bridge.sv
module tb_host_bridge;
  import host_bridge_pkg::*;

  localparam int MAX_CYCLES = 20000;  // Longest test needs well under 1000 cycles

  logic      userclk2;
  logic      reset;
  logic      awvalid;
  logic      awready;
  axi_addr_t awaddr;
  axi_id_t   awid;
  logic      wvalid;
  logic      wready;
  word_t     wdata;
  logic      bvalid;
  logic      bready;
  axi_id_t   bid;
  logic      arvalid;
  logic      arready;
  axi_addr_t araddr;
  axi_id_t   arid;
  logic      rvalid;
  logic      rready;
  logic      rlast;
  word_t     rdata;
  axi_id_t   rid;
  logic      host_in_valid;
  logic      host_in_ready;
  half_t     host_in_bits;
  logic      host_out_valid;
  logic      host_out_ready;
  half_t     host_out_bits;
  logic      cpu_reset;

  int        mismatch_count;
  int        other_count;
  int        cycle_count = 0;
  word_t     lcg_state;
  half_t     exp_in [$];   // Halfwords expected on host_in, in order

  tb_clock_gen u_clock_gen (
    .userclk2 (userclk2),
    .reset    (reset)
  );

  host_bridge_top u_dut (
    .userclk2       (userclk2),
    .reset          (reset),
    .awvalid        (awvalid),
    .awready        (awready),
    .awaddr         (awaddr),
    .awid           (awid),
    .wvalid         (wvalid),
    .wready         (wready),
    .wdata          (wdata),
    .bvalid         (bvalid),
    .bready         (bready),
    .bid            (bid),
    .arvalid        (arvalid),
    .arready        (arready),
    .araddr         (araddr),
    .arid           (arid),
    .rvalid         (rvalid),
    .rready         (rready),
    .rlast          (rlast),
    .rdata          (rdata),
    .rid            (rid),
    .host_in_valid  (host_in_valid),
    .host_in_ready  (host_in_ready),
    .host_in_bits   (host_in_bits),
    .host_out_valid (host_out_valid),
    .host_out_ready (host_out_ready),
    .host_out_bits  (host_out_bits),
    .cpu_reset      (cpu_reset)
  );

  // --------------------------------------------------
  // Random numbers and compare tasks
  // --------------------------------------------------
  function automatic word_t next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic int rand_below(input int n);
    word_t r;
    r = next_rand();
    return int'(r[30:16]) % n;  // Upper bits are the better ones
  endfunction

  task automatic compare_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
    begin
      mismatch_count = mismatch_count + 1;
      $display("FAILED time %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_half(input string name, input half_t got, input half_t exp);
    if (got !== exp)
    begin
      mismatch_count = mismatch_count + 1;
      $display("FAILED time %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_id(input string name, input axi_id_t got, input axi_id_t exp);
    if (got !== exp)
    begin
      mismatch_count = mismatch_count + 1;
      $display("FAILED time %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_count(input string name, input fifo_count_t got,
                               input fifo_count_t exp);
    if (got !== exp)
    begin
      mismatch_count = mismatch_count + 1;
      $display("FAILED time %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      mismatch_count = mismatch_count + 1;
      $display("FAILED time %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic report_other(input string what);
    other_count = other_count + 1;
    $display("Error at time %0t: %s", $time, what);
  endtask

  // --------------------------------------------------
  // Bus helpers
  // --------------------------------------------------
  task automatic axi_write_start(input reg_index_t index, input word_t data, input axi_id_t id);
    @(posedge userclk2);
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    awaddr  <= axi_addr_t'(index) << REG_LSB;
    awid    <= id;
    wdata   <= data;
  endtask

  task automatic axi_write_finish(input axi_id_t id);
    do @(negedge userclk2); while (!awready);
    compare_flag("wready", wready, 1'b1);  // Rises with awready
    @(posedge userclk2);  // Address and data handshake
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    bready  <= 1'b1;
    do @(negedge userclk2); while (!bvalid);
    compare_id("bid", bid, id);
    @(posedge userclk2);
    bready <= 1'b0;
  endtask

  task automatic axi_write(input reg_index_t index, input word_t data, input axi_id_t id);
    axi_write_start(index, data, id);
    axi_write_finish(id);
  endtask

  task automatic axi_read(input reg_index_t index, output word_t data);
    axi_id_t id;
    id = axi_id_t'(next_rand() >> 8);
    @(posedge userclk2);
    arvalid <= 1'b1;
    araddr  <= axi_addr_t'(index) << REG_LSB;
    arid    <= id;
    do @(negedge userclk2); while (!arready);
    @(posedge userclk2);
    arvalid <= 1'b0;
    rready  <= 1'b1;
    do @(negedge userclk2); while (!rvalid);
    data = rdata;
    compare_id("rid", rid, id);
    compare_flag("rlast", rlast, 1'b1);
    @(posedge userclk2);  // Read data handshake
    rready <= 1'b0;
  endtask

  task automatic read_count(input fifo_count_t exp);
    word_t data;
    axi_read(RD_COUNT, data);
    compare_count("RD_COUNT", data[5:0], exp);
    if (data[31:6] != '0)
      report_other("RD_COUNT returned nonzero upper bits");
  endtask

  task automatic send_half(input half_t h);
    @(posedge userclk2);
    host_out_valid <= 1'b1;
    host_out_bits  <= h;
    do @(negedge userclk2); while (!host_out_ready);
    @(posedge userclk2);
    host_out_valid <= 1'b0;
  endtask

  task automatic receive_halves(input int n, input bit random_ready);
    int    taken;
    bit    rdy;
    half_t exp;
    taken = 0;
    while (taken < n)
    begin
      @(posedge userclk2);
      rdy = random_ready ? (rand_below(2) == 1) : 1'b1;
      host_in_ready <= rdy;
      @(negedge userclk2);
      if (host_in_valid && host_in_ready)  // Transfer on the coming edge
      begin
        if (exp_in.size() == 0)
          report_other("host_in delivered a halfword that was never written");
        else
        begin
          exp = exp_in.pop_front();
          compare_half("host_in_bits", host_in_bits, exp);
        end
        taken = taken + 1;
      end
    end
    @(posedge userclk2);
    host_in_ready <= 1'b0;
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic test_after_reset();
    word_t data;
    @(negedge userclk2);
    compare_flag("host_in_valid", host_in_valid, 1'b0);
    compare_flag("cpu_reset", cpu_reset, 1'b0);
    compare_flag("host_out_ready", host_out_ready, 1'b1);
    compare_flag("bvalid", bvalid, 1'b0);
    compare_flag("awready", awready, 1'b0);
    compare_flag("wready", wready, 1'b0);
    read_count(6'd0);
    axi_read(5'd7, data);  // Unmapped index
    compare_word("unmapped rdata", data, 32'h0);
  endtask

  task automatic test_out_pairing();
    half_t lo;
    half_t hi;
    word_t data;
    word_t exp_words [$];
    for (int i = 0; i < 5; i++)
    begin
      lo = half_t'(next_rand() >> 8);
      hi = half_t'(next_rand() >> 8);
      exp_words.push_back({hi, lo});  // Second halfword on top
      repeat (rand_below(4)) @(posedge userclk2);
      send_half(lo);
      repeat (rand_below(4)) @(posedge userclk2);
      send_half(hi);
    end
    read_count(6'd5);
    for (int i = 0; i < 5; i++)
    begin
      axi_read(RD_FIFO, data);
      compare_word("RD_FIFO", data, exp_words.pop_front());
    end
    read_count(6'd0);
  endtask

  task automatic test_in_unpacking();
    word_t words [6];
    for (int i = 0; i < 6; i++)
    begin
      words[i] = next_rand();
      exp_in.push_back(words[i][15:0]);
      exp_in.push_back(words[i][31:16]);
    end
    fork
      begin
        for (int i = 0; i < 6; i++)
          axi_write(WR_FIFO, words[i], axi_id_t'(12'h300 + i));
      end
      begin
        receive_halves(12, 1'b1);
      end
    join
  endtask

  task automatic test_in_backpressure();
    word_t w;
    bit    early;
    early = 1'b0;
    for (int i = 0; i < 32; i++)
    begin
      w = next_rand();
      exp_in.push_back(w[15:0]);
      exp_in.push_back(w[31:16]);
      axi_write(WR_FIFO, w, axi_id_t'(12'h400 + i));
    end
    // Inbound FIFO full, this write must stall
    w = next_rand();
    exp_in.push_back(w[15:0]);
    exp_in.push_back(w[31:16]);
    axi_write_start(WR_FIFO, w, 12'h4ff);
    repeat (50)
    begin
      @(negedge userclk2);
      if (awready || wready)
        early = 1'b1;
    end
    if (early)
      report_other("write into a full inbound FIFO was accepted");
    receive_halves(2, 1'b0);
    axi_write_finish(12'h4ff);
    receive_halves(64, 1'b0);
    @(negedge userclk2);
    compare_flag("host_in_valid", host_in_valid, 1'b0);
    if (exp_in.size() != 0)
      report_other("inbound halfwords missing after drain");
  endtask

  task automatic test_target_reset();
    int pulses;
    bit write_done;
    bit stray_valid;
    pulses      = 0;
    write_done  = 1'b0;
    stray_valid = 1'b0;
    fork
      begin
        axi_write(WR_RESET, next_rand(), 12'h5a5);
        write_done = 1'b1;
      end
      begin
        while (!write_done)
        begin
          @(negedge userclk2);
          if (cpu_reset)
            pulses = pulses + 1;
          if (host_in_valid)
            stray_valid = 1'b1;
        end
      end
    join
    if (pulses != 1)
    begin
      mismatch_count = mismatch_count + 1;
      $display("FAILED time %0t: cpu_reset high cycles got %0d expected 1", $time, pulses);
    end
    if (stray_valid)
      report_other("target reset write raised host_in_valid");
  endtask

  task automatic test_out_full();
    half_t lo;
    half_t hi;
    word_t first;
    word_t data;
    for (int i = 0; i < 32; i++)
    begin
      lo = half_t'(next_rand() >> 8);
      hi = half_t'(next_rand() >> 8);
      if (i == 0)
        first = {hi, lo};
      send_half(lo);
      send_half(hi);
    end
    @(negedge userclk2);
    compare_flag("host_out_ready", host_out_ready, 1'b0);
    read_count(6'd32);  // Full FIFO must not read as 0
    axi_read(RD_FIFO, data);
    compare_word("RD_FIFO", data, first);
    @(negedge userclk2);
    compare_flag("host_out_ready", host_out_ready, 1'b1);
    read_count(6'd31);
  endtask

  // --------------------------------------------------
  // Run control
  // --------------------------------------------------
  always @(posedge userclk2)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES)
    begin
      $display("Timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial
  begin
    mismatch_count = 0;
    other_count    = 0;
    lcg_state      = 32'd17233;
    awvalid        = 1'b0;
    awaddr         = '0;
    awid           = '0;
    wvalid         = 1'b0;
    wdata          = '0;
    bready         = 1'b0;
    arvalid        = 1'b0;
    araddr         = '0;
    arid           = '0;
    rready         = 1'b0;
    host_in_ready  = 1'b0;
    host_out_valid = 1'b0;
    host_out_bits  = '0;

    @(negedge userclk2);
    while (reset)
    begin
      @(negedge userclk2);
    end

    test_after_reset();
    test_out_pairing();
    test_in_unpacking();
    test_in_backpressure();
    test_target_reset();
    test_out_full();

    $display("Summary: %0d value mismatches, %0d other errors", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: sim/tb_clock_gen.sv
module tb_clock_gen (
  output logic userclk2,
  output logic reset
);

  localparam int PERIOD       = 40;
  localparam int RESET_CYCLES = 2;

  initial
  begin
    userclk2 = 1'b0;
    forever #(PERIOD / 2) userclk2 = ~userclk2;
  end

  // Synchronous reset, released on a rising edge
  initial
  begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge userclk2);
    reset <= 1'b0;
  end

endmodule

// File: source/host_bridge_top.sv
module host_bridge_top (
  input  logic                       userclk2,
  input  logic                       reset,
  // AXI write address
  input  logic                       awvalid,
  output logic                       awready,
  input  host_bridge_pkg::axi_addr_t awaddr,
  input  host_bridge_pkg::axi_id_t   awid,
  // AXI write data
  input  logic                       wvalid,
  output logic                       wready,
  input  host_bridge_pkg::word_t     wdata,
  // AXI write response
  output logic                       bvalid,
  input  logic                       bready,
  output host_bridge_pkg::axi_id_t   bid,
  // AXI read address
  input  logic                       arvalid,
  output logic                       arready,
  input  host_bridge_pkg::axi_addr_t araddr,
  input  host_bridge_pkg::axi_id_t   arid,
  // AXI read data
  output logic                       rvalid,
  input  logic                       rready,
  output logic                       rlast,
  output host_bridge_pkg::word_t     rdata,
  output host_bridge_pkg::axi_id_t   rid,
  // Host channel toward the target
  output logic                       host_in_valid,
  input  logic                       host_in_ready,
  output host_bridge_pkg::half_t     host_in_bits,
  // Host channel from the target
  input  logic                       host_out_valid,
  output logic                       host_out_ready,
  input  host_bridge_pkg::half_t     host_out_bits,
  output logic                       cpu_reset
);

  host_reg_if regs ();

  // --------------------------------------------------
  // Register access
  // --------------------------------------------------
  axi_reg_fsm u_fsm (
    .userclk2  (userclk2),
    .reset     (reset),
    .awvalid   (awvalid),
    .awready   (awready),
    .awaddr    (awaddr),
    .awid      (awid),
    .wvalid    (wvalid),
    .wready    (wready),
    .wdata     (wdata),
    .bvalid    (bvalid),
    .bready    (bready),
    .bid       (bid),
    .arvalid   (arvalid),
    .arready   (arready),
    .araddr    (araddr),
    .arid      (arid),
    .rvalid    (rvalid),
    .rready    (rready),
    .rlast     (rlast),
    .rdata     (rdata),
    .rid       (rid),
    .cpu_reset (cpu_reset),
    .regs      (regs.fsm)
  );

  // --------------------------------------------------
  // FIFO paths
  // --------------------------------------------------
  host_in_path u_in_path (
    .userclk2      (userclk2),
    .reset         (reset),
    .regs          (regs.in_path),
    .host_in_valid (host_in_valid),
    .host_in_bits  (host_in_bits),
    .host_in_ready (host_in_ready)
  );

  host_out_path u_out_path (
    .userclk2       (userclk2),
    .reset          (reset),
    .regs           (regs.out_path),
    .host_out_valid (host_out_valid),
    .host_out_bits  (host_out_bits),
    .host_out_ready (host_out_ready)
  );

endmodule

// File: source/axi_reg_fsm.sv
module axi_reg_fsm (
  input  logic                       userclk2,
  input  logic                       reset,
  // Write address
  input  logic                       awvalid,
  output logic                       awready,
  input  host_bridge_pkg::axi_addr_t awaddr,
  input  host_bridge_pkg::axi_id_t   awid,
  // Write data
  input  logic                       wvalid,
  output logic                       wready,
  input  host_bridge_pkg::word_t     wdata,
  // Write response
  output logic                       bvalid,
  input  logic                       bready,
  output host_bridge_pkg::axi_id_t   bid,
  // Read address
  input  logic                       arvalid,
  output logic                       arready,
  input  host_bridge_pkg::axi_addr_t araddr,
  input  host_bridge_pkg::axi_id_t   arid,
  // Read data
  output logic                       rvalid,
  input  logic                       rready,
  output logic                       rlast,
  output host_bridge_pkg::word_t     rdata,
  output host_bridge_pkg::axi_id_t   rid,
  output logic                       cpu_reset,
  host_reg_if.fsm                    regs
);
  import host_bridge_pkg::*;

  rd_state_e  rd_state;
  reg_index_t rd_index;
  axi_id_t    rd_id;

  wr_state_e  wr_state;
  reg_index_t wr_index;
  axi_id_t    wr_id;
  word_t      wr_data;
  logic       wr_go;
  logic       wr_accept;

  // --------------------------------------------------
  // Read channel
  // --------------------------------------------------
  always_ff @(posedge userclk2)
  begin
    if (reset)
    begin
      rd_state <= RD_IDLE;
      rd_index <= '0;
    end
    else
    begin
      case (rd_state)
        RD_IDLE:
          if (arvalid)
          begin
            rd_state <= RD_DATA;
            rd_index <= araddr[REG_MSB:REG_LSB];
          end
        RD_DATA:
          if (rready)
            rd_state <= RD_IDLE;
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge userclk2)
  begin
    if (rd_state == RD_IDLE && arvalid)
      rd_id <= arid;
  end

  assign arready = (rd_state == RD_IDLE);
  assign rvalid  = (rd_state == RD_DATA);
  assign rlast   = (rd_state == RD_DATA);   // Single-beat reads
  assign rid     = rd_id;
  assign regs.pop = rvalid && rready && (rd_index == RD_FIFO);

  // Read data mux
  always_comb
  begin
    case (rd_index)
      RD_COUNT: rdata = word_t'(regs.out_count);
      RD_FIFO:  rdata = regs.out_word;
      default:  rdata = '0;   // Unmapped
    endcase
  end

  // --------------------------------------------------
  // Write channel
  // --------------------------------------------------
  // Only FIFO writes wait for room
  assign wr_go     = (wr_index != WR_FIFO) || !regs.in_full;
  assign wr_accept = (wr_state == WR_WRITE) && wr_go;

  always_ff @(posedge userclk2)
  begin
    if (reset)
    begin
      wr_state <= WR_IDLE;
      wr_index <= '0;
    end
    else
    begin
      case (wr_state)
        WR_IDLE:
          if (awvalid && wvalid)
          begin
            wr_state <= WR_WRITE;
            wr_index <= awaddr[REG_MSB:REG_LSB];
          end
        WR_WRITE:
          if (wr_go)
            wr_state <= WR_ACK;
        WR_ACK:
          if (bready)
            wr_state <= WR_IDLE;
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge userclk2)
  begin
    if (wr_state == WR_IDLE && awvalid && wvalid)
    begin
      wr_id   <= awid;
      wr_data <= wdata;
    end
  end

  assign awready = wr_accept;
  assign wready  = wr_accept;
  assign bvalid  = (wr_state == WR_ACK);
  assign bid     = wr_id;

  // Index decode
  assign regs.push      = wr_accept && (wr_index == WR_FIFO);
  assign regs.push_data = wr_data;
  assign cpu_reset      = wr_accept && (wr_index == WR_RESET);

endmodule

// File: source/host_out_path.sv
module host_out_path (
  input  logic                   userclk2,
  input  logic                   reset,
  host_reg_if.out_path           regs,
  input  logic                   host_out_valid,
  input  host_bridge_pkg::half_t host_out_bits,
  output logic                   host_out_ready
);
  import host_bridge_pkg::*;

  half_t low_half;     // First halfword of the pair
  logic  high_sel;     // Set once the low half is held
  logic  half_taken;
  logic  fifo_full;
  logic  pair_done;

  assign host_out_ready = !fifo_full;
  assign half_taken     = host_out_valid && host_out_ready;

  // Only a real second halfword completes a word
  assign pair_done = half_taken && high_sel;

  always_ff @(posedge userclk2)
  begin
    if (reset)
      high_sel <= 1'b0;
    else if (half_taken)
      high_sel <= !high_sel;
  end

  // Payload holding register
  always_ff @(posedge userclk2)
  begin
    if (half_taken && !high_sel)
      low_half <= host_out_bits;
  end

  // Outbound word FIFO, drained by RD_FIFO reads
  word_fifo u_fifo (
    .userclk2 (userclk2),
    .reset    (reset),
    .wr_en    (pair_done),
    .rd_en    (regs.pop),
    .din      ({host_out_bits, low_half}),  // Second half on top
    .dout     (regs.out_word),
    .empty    (),
    .full     (fifo_full),
    .count    (regs.out_count)
  );

endmodule

// File: source/host_in_path.sv
module host_in_path (
  input  logic                   userclk2,
  input  logic                   reset,
  host_reg_if.in_path            regs,
  output logic                   host_in_valid,
  output host_bridge_pkg::half_t host_in_bits,
  input  logic                   host_in_ready
);
  import host_bridge_pkg::*;

  word_t head_word;
  logic  fifo_empty;
  logic  high_sel;    // 0 = low half next, 1 = high half next
  logic  half_taken;

  // Inbound word FIFO, filled from the register write path
  word_fifo u_fifo (
    .userclk2 (userclk2),
    .reset    (reset),
    .wr_en    (regs.push),
    .rd_en    (half_taken && high_sel),  // Pop once the high half is gone
    .din      (regs.push_data),
    .dout     (head_word),
    .empty    (fifo_empty),
    .full     (regs.in_full),
    .count    ()
  );

  assign host_in_valid = !fifo_empty;
  assign half_taken    = host_in_valid && host_in_ready;

  // Low half goes out first
  assign host_in_bits = high_sel ? head_word[31:16] : head_word[15:0];

  always_ff @(posedge userclk2)
  begin
    if (reset)
      high_sel <= 1'b0;
    else if (half_taken)
      high_sel <= !high_sel;
  end

endmodule

// File: source/word_fifo.sv
module word_fifo (
  input  logic                        userclk2,
  input  logic                        reset,
  input  logic                        wr_en,
  input  logic                        rd_en,
  input  host_bridge_pkg::word_t      din,
  output host_bridge_pkg::word_t      dout,
  output logic                        empty,
  output logic                        full,
  output host_bridge_pkg::fifo_count_t count
);
  import host_bridge_pkg::*;

  word_t                           mem [FIFO_DEPTH];
  logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
  fifo_count_t                     occupancy;
  logic                            do_write;
  logic                            do_read;

  assign do_write = wr_en && !full;   // Drop pushes while full
  assign do_read  = rd_en && !empty;  // Drop pops while empty

  assign empty = (occupancy == '0);
  assign full  = (occupancy == fifo_count_t'(FIFO_DEPTH));
  assign count = occupancy;

  // Head word is visible without latency
  assign dout = mem[rd_ptr];

  // --------------------------------------------------
  // Storage
  // --------------------------------------------------
  always_ff @(posedge userclk2)
  begin
    if (do_write)
      mem[wr_ptr] <= din;
  end

  // --------------------------------------------------
  // Pointers and occupancy
  // --------------------------------------------------
  always_ff @(posedge userclk2)
  begin
    if (reset)
    begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      occupancy <= '0;
    end
    else
    begin
      if (do_write)
        wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
      if (do_read)
        rd_ptr <= rd_ptr + 1'b1;

      case ({do_write, do_read})
        2'b10:   occupancy <= occupancy + 1'b1;
        2'b01:   occupancy <= occupancy - 1'b1;
        default: occupancy <= occupancy;  // Both or neither
      endcase
    end
  end

endmodule

// File: source/host_reg_if.sv
interface host_reg_if;
  import host_bridge_pkg::*;

  // Inbound side
  logic        push;       // One cycle per accepted WR_FIFO write
  word_t       push_data;
  logic        in_full;

  // Outbound side
  logic        pop;        // Read beat of RD_FIFO accepted
  word_t       out_word;   // Head of outbound FIFO
  fifo_count_t out_count;

  modport fsm (
    output push,
    output push_data,
    output pop,
    input  in_full,
    input  out_word,
    input  out_count
  );

  modport in_path (
    input  push,
    input  push_data,
    output in_full
  );

  modport out_path (
    input  pop,
    output out_word,
    output out_count
  );

endinterface

// File: source/host_bridge_pkg.sv
package host_bridge_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------
  typedef logic [31:0] word_t;        // AXI data and FIFO entry
  typedef logic [15:0] half_t;        // Host channel halfword
  typedef logic [11:0] axi_id_t;
  typedef logic [31:0] axi_addr_t;
  typedef logic [4:0]  reg_index_t;
  typedef logic [5:0]  fifo_count_t;  // One bit wider than the pointers so 32 fits

  localparam int FIFO_DEPTH = 32;

  // Register index field inside the byte address
  localparam int REG_LSB = 2;
  localparam int REG_MSB = 6;

  // --------------------------------------------------
  // Register map
  // --------------------------------------------------
  typedef enum reg_index_t {
    RD_COUNT = 5'd0,   // Outbound FIFO occupancy
    RD_FIFO  = 5'd1    // Outbound head word, pops on read
  } rd_reg_e;

  typedef enum reg_index_t {
    WR_FIFO  = 5'd0,   // Push into inbound FIFO
    WR_RESET = 5'd31   // One-cycle target reset
  } wr_reg_e;

  // State machines
  typedef enum logic {
    RD_IDLE,
    RD_DATA
  } rd_state_e;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_WRITE,
    WR_ACK
  } wr_state_e;

endpackage
